// ==== rtl/cgol_grid_pkg.sv ====
`default_nettype none

package cgol_grid_pkg;

  // Grid geometry limits on the torus
  localparam int max_width     = 64;              // Cells per row, multiple of 8
  localparam int max_height    = 64;              // Rows per grid
  localparam int max_row_bytes = max_width / 8;   // One bit per cell
  localparam int addr_width    = 16;              // Byte address span of the grid memory

  // One grid row, also the memory data word
  typedef logic [max_width-1:0] row_t;

  typedef logic [addr_width-1:0] addr_t;          // Byte address

  // Row index or count, must reach max_height itself
  typedef logic [$clog2(max_height):0] row_idx_t;

  // Column count, holds max_width
  typedef logic [$clog2(max_width):0] width_t;

  typedef logic [$clog2(max_row_bytes):0] row_bytes_t;  // 1 to 8 bytes per row

  typedef logic [1:0] win_slot_t;                 // Window slot 0..2

endpackage

`default_nettype wire

// ==== rtl/cgol_regs_pkg.sv ====
`default_nettype none

package cgol_regs_pkg;

  localparam int num_regs = 5;                    // Host visible registers

  typedef logic [31:0] reg_t;                     // Register word as seen by software

  // Register indexes, fixed by the software driver
  typedef enum logic [2:0] {
    grid_base_addr_reg = 3'd0,                    // Grid byte address in memory
    grid_width_reg     = 3'd1,                    // Columns
    grid_height_reg    = 3'd2,                    // Rows
    start_reg          = 3'd3,                    // Nonzero write kicks off one generation
    done_reg           = 3'd4                     // Completion flag, clear on read
  } reg_idx_e;

  localparam int done_bit = 0;                    // Done flag position in done_reg

endpackage

`default_nettype wire

// ==== rtl/window_ctl_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface window_ctl_if;

  logic                      load_slot;     // Write rd_data into slot_sel
  cgol_grid_pkg::win_slot_t  slot_sel;      // Target slot of a load
  logic                      hold_capture;  // Also copy into hold entry slot_sel
  logic                      reload_hold;   // Copy hold entry into the next-row slot
  logic                      hold_sel;      // Hold entry to reload
  logic                      roll;          // Advance prev/crnt/next roles

  modport sequencer (
    output load_slot,
    output slot_sel,
    output hold_capture,
    output reload_hold,
    output hold_sel,
    output roll
  );

  modport window (
    input load_slot,
    input slot_sel,
    input hold_capture,
    input reload_hold,
    input hold_sel,
    input roll
  );

endinterface

`default_nettype wire

// ==== rtl/cgol_host_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module cgol_host_regs (
  input  wire                                                 clk,
  input  wire                                                 rst_n,
  input  cgol_regs_pkg::reg_t [cgol_regs_pkg::num_regs-1:0]   host_regs,
  input  wire [cgol_regs_pkg::num_regs-1:0]                   host_regs_valid_pulse,
  input  wire [cgol_regs_pkg::num_regs-1:0]                   host_regs_read_pulse,
  input  wire                                                 finish,
  output cgol_regs_pkg::reg_t [cgol_regs_pkg::num_regs-1:0]   host_regs_data_out,
  output logic [cgol_regs_pkg::num_regs-1:0]                  host_regs_valid_out,
  output logic                                                start,
  output logic                                                done_cleared,
  output cgol_grid_pkg::addr_t                                base_addr,
  output cgol_grid_pkg::row_bytes_t                           row_bytes,
  output cgol_grid_pkg::width_t                               grid_width,
  output cgol_grid_pkg::row_idx_t                             grid_height
);

  logic done_q;                                   // Sticky done flag

  // Configuration fields straight from the software view
  assign base_addr   = host_regs[cgol_regs_pkg::grid_base_addr_reg][15:0];
  assign grid_width  = host_regs[cgol_regs_pkg::grid_width_reg][6:0];
  assign grid_height = host_regs[cgol_regs_pkg::grid_height_reg][6:0];
  assign row_bytes   = grid_width[6:3];           // Width / 8, width is a multiple of 8

  assign start = host_regs_valid_pulse[cgol_regs_pkg::start_reg] &&
                 (host_regs[cgol_regs_pkg::start_reg] != '0);   // Only a nonzero write starts

  assign done_cleared = host_regs_read_pulse[cgol_regs_pkg::done_reg] && done_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_q <= 1'b0;
    end else if (finish) begin
      done_q <= 1'b1;                             // Set wins over a same-cycle read
    end else if (host_regs_read_pulse[cgol_regs_pkg::done_reg]) begin
      done_q <= 1'b0;                             // Clear on read
    end
  end

  // Only the done word is ever presented to software
  always_comb begin
    host_regs_data_out = '0;
    host_regs_data_out[cgol_regs_pkg::done_reg][cgol_regs_pkg::done_bit] = done_q;
    host_regs_valid_out = '0;
    host_regs_valid_out[cgol_regs_pkg::done_reg] = done_q;
  end

  // A new generation must not complete before software saw the last one
  a_finish_after_clear : assert property (@(posedge clk) disable iff (!rst_n)
    finish |-> !done_q);

endmodule

`default_nettype wire

// ==== rtl/cgol_row_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module cgol_row_sequencer (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        start,
  input  cgol_grid_pkg::addr_t       base_addr,
  input  cgol_grid_pkg::row_bytes_t  row_bytes,
  input  cgol_grid_pkg::width_t      grid_width,
  input  cgol_grid_pkg::row_idx_t    grid_height,
  input  wire                        done_cleared,
  input  wire                        rd_valid,
  input  wire                        wr_ack,
  input  cgol_grid_pkg::row_t        new_row,
  output logic                       rd_req,
  output cgol_grid_pkg::addr_t       rd_addr,
  output cgol_grid_pkg::row_bytes_t  rd_size,
  output logic                       wr_req,
  output cgol_grid_pkg::addr_t       wr_addr,
  output cgol_grid_pkg::row_bytes_t  wr_size,
  output cgol_grid_pkg::row_t        wr_data,
  output logic                       finish,
  window_ctl_if.sequencer            ctl
);

  // One-hot sequencer, one flop per state
  typedef enum logic [6:0] {
    st_idle       = 7'b0000001,
    st_head_load  = 7'b0000010,                   // Rows 0 and 1, also into hold buffer
    st_third_load = 7'b0000100,                   // Row 2
    st_write      = 7'b0001000,
    st_read       = 7'b0010000,                   // Row r+2 into the freed slot
    st_wrap       = 7'b0100000,                   // Hold entry back into the window
    st_done       = 7'b1000000
  } state_e;

  state_e                     state;
  cgol_grid_pkg::row_idx_t    rd_row;             // Next row to read
  cgol_grid_pkg::row_idx_t    wr_row;             // Row being written
  cgol_grid_pkg::win_slot_t   next_slot;          // Slot holding the next row

  // Window control follows the memory answers in the same cycle
  assign ctl.load_slot    = rd_req && rd_valid;
  assign ctl.slot_sel     = (state == st_read) ? next_slot : rd_row[1:0];
  assign ctl.hold_capture = (state == st_head_load);
  assign ctl.reload_hold  = (state == st_wrap);
  assign ctl.hold_sel     = (wr_row == '0);       // Row 0 update needs row 1 as next
  assign ctl.roll         = (state == st_write) && wr_req && wr_ack;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_idle;
      rd_req    <= 1'b0;
      wr_req    <= 1'b0;
      rd_addr   <= '0;
      wr_addr   <= '0;
      rd_size   <= '0;
      wr_size   <= '0;
      wr_data   <= '0;
      rd_row    <= '0;
      wr_row    <= '0;
      next_slot <= '0;
      finish    <= 1'b0;
    end else begin
      finish <= 1'b0;                             // Single-cycle pulse
      if (ctl.roll) begin
        next_slot <= (next_slot == 2'd2) ? 2'd0 : next_slot + 2'd1;  // Old prev slot frees up
      end
      unique case (state)
        st_idle: begin
          if (start) begin
            state     <= st_head_load;
            rd_req    <= 1'b1;                    // First read goes out right away
            rd_addr   <= base_addr;
            rd_size   <= row_bytes;
            wr_size   <= row_bytes;
            wr_addr   <= base_addr + cgol_grid_pkg::addr_t'(row_bytes);  // Row 1 first
            rd_row    <= '0;
            wr_row    <= 7'd1;
            next_slot <= 2'd2;
          end
        end
        st_head_load, st_third_load, st_read: begin
          if (!rd_req) begin
            rd_req <= 1'b1;                       // Raise after the idle gap
          end else if (rd_valid) begin
            rd_req  <= 1'b0;
            rd_row  <= rd_row + 7'd1;
            rd_addr <= rd_addr + cgol_grid_pkg::addr_t'(rd_size);
            if (state == st_head_load) begin
              if (rd_row[0]) begin
                state <= st_third_load;           // Rows 0 and 1 are in
              end
            end else begin
              state <= st_write;
            end
          end
        end
        st_write: begin
          if (!wr_req) begin
            wr_req  <= 1'b1;
            wr_data <= new_row;                   // Window settled one cycle ago
          end else if (wr_ack) begin
            wr_req <= 1'b0;
            if (wr_row == grid_height - 7'd1) begin
              wr_row  <= '0;                      // Row 0 goes last
              wr_addr <= base_addr;
            end else begin
              wr_row  <= wr_row + 7'd1;
              wr_addr <= wr_addr + cgol_grid_pkg::addr_t'(wr_size);
            end
            if (wr_row == '0) begin
              state  <= st_done;
              finish <= 1'b1;
            end else if (rd_row != grid_height) begin
              state <= st_read;
            end else begin
              state <= st_wrap;                   // All rows read, use the hold buffer
            end
          end
        end
        st_wrap: state <= st_write;               // Reload takes effect next cycle
        st_done: begin
          if (done_cleared) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  a_req_exclusive : assert property (@(posedge clk) disable iff (!rst_n)
    !(rd_req && wr_req));

  a_state_onehot : assert property (@(posedge clk) disable iff (!rst_n)
    $onehot(state));

  // Software must program a legal torus before it starts
  a_start_config : assert property (@(posedge clk) disable iff (!rst_n)
    start |-> (grid_width[2:0] == 3'd0) && (grid_width != '0) &&
              (grid_width <= cgol_grid_pkg::max_width) &&
              (grid_height >= 7'd3) && (grid_height <= cgol_grid_pkg::max_height));

endmodule

`default_nettype wire

// ==== rtl/cgol_row_window.sv ====
`timescale 1ns/10ps
`default_nettype none

module cgol_row_window (
  input  wire                  clk,
  input  wire                  rst_n,
  input  cgol_grid_pkg::row_t  rd_data,
  window_ctl_if.window         ctl,
  output cgol_grid_pkg::row_t  prev_row,
  output cgol_grid_pkg::row_t  crnt_row,
  output cgol_grid_pkg::row_t  next_row
);

  cgol_grid_pkg::row_t       slot_q [3];          // Rolling three-row window
  cgol_grid_pkg::row_t       hold_q [2];          // Rows 0 and 1 for the wrap rows
  cgol_grid_pkg::win_slot_t  prev_ptr;            // Slot playing the prev role
  cgol_grid_pkg::win_slot_t  crnt_slot;
  cgol_grid_pkg::win_slot_t  next_slot;

  // Roles follow the pointer modulo 3
  assign crnt_slot = (prev_ptr == 2'd2) ? 2'd0 : prev_ptr + 2'd1;
  assign next_slot = (crnt_slot == 2'd2) ? 2'd0 : crnt_slot + 2'd1;

  assign prev_row = slot_q[prev_ptr];
  assign crnt_row = slot_q[crnt_slot];
  assign next_row = slot_q[next_slot];

  always_ff @(posedge clk) begin
    if (ctl.load_slot) begin
      slot_q[ctl.slot_sel] <= rd_data;
      if (ctl.hold_capture) begin
        hold_q[ctl.slot_sel[0]] <= rd_data;       // Keep row 0 or 1 for later
      end
    end else if (ctl.reload_hold) begin
      slot_q[next_slot] <= hold_q[ctl.hold_sel];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prev_ptr <= '0;
    end else if (ctl.load_slot && ctl.hold_capture && ctl.slot_sel == 2'd0) begin
      prev_ptr <= '0;                             // Row 0 arriving starts a fresh pass
    end else if (ctl.roll) begin
      prev_ptr <= crnt_slot;
    end
  end

  // Memory load and hold reload share the slot write port
  a_no_load_reload : assert property (@(posedge clk) disable iff (!rst_n)
    !(ctl.load_slot && ctl.reload_hold));

endmodule

`default_nettype wire

// ==== rtl/cgol_life_rule.sv ====
`timescale 1ns/10ps
`default_nettype none

module cgol_life_rule (
  input  cgol_grid_pkg::row_t    prev_row,
  input  cgol_grid_pkg::row_t    crnt_row,
  input  cgol_grid_pkg::row_t    next_row,
  input  cgol_grid_pkg::width_t  grid_width,
  output cgol_grid_pkg::row_t    new_row
);

  logic [1:0] col_sum [cgol_grid_pkg::max_width];  // Live cells per column (0 to 3)

  // Vertical sums shared by three neighbouring cells each
  always_comb begin
    for (int i = 0; i < cgol_grid_pkg::max_width; i++) begin
      if (i < grid_width) begin
        col_sum[i] = {1'b0, prev_row[i]} + {1'b0, crnt_row[i]} + {1'b0, next_row[i]};
      end else begin
        col_sum[i] = 2'd0;                        // Beyond the grid
      end
    end
  end

  always_comb begin
    logic [3:0] nbr;                              // Neighbour count up to 8
    int         lft;
    int         rgt;
    nbr     = '0;
    lft     = 0;
    rgt     = 0;
    new_row = '0;                                 // Columns past grid_width stay dead
    for (int i = 0; i < cgol_grid_pkg::max_width; i++) begin
      if (i < grid_width) begin
        lft = (i == 0) ? int'(grid_width) - 1 : i - 1;  // Column 0 wraps to the far edge
        rgt = (i == int'(grid_width) - 1) ? 0 : i + 1;  // Far edge wraps to column 0
        nbr = {2'b00, col_sum[lft]} + {2'b00, col_sum[i]} + {2'b00, col_sum[rgt]} -
              {3'b000, crnt_row[i]};              // Cell itself is not a neighbour
        new_row[i] = (nbr == 4'd3) || (crnt_row[i] && nbr == 4'd2);
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/cgol_torus_accel.sv ====
`timescale 1ns/10ps
`default_nettype none

module cgol_torus_accel (
  input  wire                                                clk,
  input  wire                                                rst_n,
  // Host register port
  input  cgol_regs_pkg::reg_t [cgol_regs_pkg::num_regs-1:0]  host_regs,
  input  wire [cgol_regs_pkg::num_regs-1:0]                  host_regs_valid_pulse,
  input  wire [cgol_regs_pkg::num_regs-1:0]                  host_regs_read_pulse,
  output cgol_regs_pkg::reg_t [cgol_regs_pkg::num_regs-1:0]  host_regs_data_out,
  output logic [cgol_regs_pkg::num_regs-1:0]                 host_regs_valid_out,
  // Memory read port
  output logic                                               rd_req,
  output cgol_grid_pkg::addr_t                               rd_addr,
  output cgol_grid_pkg::row_bytes_t                          rd_size,
  input  wire                                                rd_valid,
  input  cgol_grid_pkg::row_t                                rd_data,
  // Memory write port
  output logic                                               wr_req,
  output cgol_grid_pkg::addr_t                               wr_addr,
  output cgol_grid_pkg::row_bytes_t                          wr_size,
  output cgol_grid_pkg::row_t                                wr_data,
  input  wire                                                wr_ack
);

  logic                       start;
  logic                       finish;
  logic                       done_cleared;
  cgol_grid_pkg::addr_t       base_addr;
  cgol_grid_pkg::row_bytes_t  row_bytes;
  cgol_grid_pkg::width_t      grid_width;
  cgol_grid_pkg::row_idx_t    grid_height;
  cgol_grid_pkg::row_t        prev_row;
  cgol_grid_pkg::row_t        crnt_row;
  cgol_grid_pkg::row_t        next_row;
  cgol_grid_pkg::row_t        new_row;             // Combinational next generation

  window_ctl_if win_ctl ();                         // Sequencer to window commands

  cgol_host_regs host_regs_i (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .host_regs             (host_regs),
    .host_regs_valid_pulse (host_regs_valid_pulse),
    .host_regs_read_pulse  (host_regs_read_pulse),
    .finish                (finish),
    .host_regs_data_out    (host_regs_data_out),
    .host_regs_valid_out   (host_regs_valid_out),
    .start                 (start),
    .done_cleared          (done_cleared),
    .base_addr             (base_addr),
    .row_bytes             (row_bytes),
    .grid_width            (grid_width),
    .grid_height           (grid_height)
  );

  cgol_row_sequencer row_sequencer_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .base_addr    (base_addr),
    .row_bytes    (row_bytes),
    .grid_width   (grid_width),
    .grid_height  (grid_height),
    .done_cleared (done_cleared),
    .rd_valid     (rd_valid),
    .wr_ack       (wr_ack),
    .new_row      (new_row),
    .rd_req       (rd_req),
    .rd_addr      (rd_addr),
    .rd_size      (rd_size),
    .wr_req       (wr_req),
    .wr_addr      (wr_addr),
    .wr_size      (wr_size),
    .wr_data      (wr_data),
    .finish       (finish),
    .ctl          (win_ctl)
  );

  cgol_row_window row_window_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_data  (rd_data),
    .ctl      (win_ctl),
    .prev_row (prev_row),
    .crnt_row (crnt_row),
    .next_row (next_row)
  );

  cgol_life_rule life_rule_i (
    .prev_row   (prev_row),
    .crnt_row   (crnt_row),
    .next_row   (next_row),
    .grid_width (grid_width),
    .new_row    (new_row)
  );

endmodule

`default_nettype wire

// ==== verification/cgol_mem_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module cgol_mem_model (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        load,           // Copy load_image in on this edge
  input  wire [511:0][7:0]           load_image,
  output logic [511:0][7:0]          mem_image,      // Current contents, one byte per address
  input  wire                        rd_req,
  input  cgol_grid_pkg::addr_t       rd_addr,
  input  cgol_grid_pkg::row_bytes_t  rd_size,
  output logic                       rd_valid,
  output cgol_grid_pkg::row_t        rd_data,
  input  wire                        wr_req,
  input  cgol_grid_pkg::addr_t       wr_addr,
  input  cgol_grid_pkg::row_bytes_t  wr_size,
  input  cgol_grid_pkg::row_t        wr_data,
  output logic                       wr_ack
);

  localparam int mem_bytes = 512;

  logic [31:0] lcg_state;                          // Latency generator state
  logic [31:0] lcg_next;
  int          wait_cnt;                           // Cycles the pending request has waited
  int          lat;                                // Latency of the pending request

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  assign lcg_next = lcg_step(lcg_state);

  // Read and write requests are exclusive, so one counter serves both
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_image <= '0;
      rd_valid  <= 1'b0;
      rd_data   <= '0;
      wr_ack    <= 1'b0;
      lcg_state <= 32'd17695;
      wait_cnt  <= 0;
      lat       <= 1;                              // First request answers fast
    end else begin
      rd_valid <= 1'b0;                            // Answers are single-cycle
      wr_ack   <= 1'b0;
      if (load)
        mem_image <= load_image;
      if (!(rd_req || wr_req) || rd_valid || wr_ack) begin
        wait_cnt <= 0;                             // Idle, or request drops after its answer
      end else if (wait_cnt + 1 < lat) begin
        wait_cnt <= wait_cnt + 1;
      end else begin
        wait_cnt  <= 0;
        lat       <= 1 + int'(lcg_next[23:16] % 8'd6);  // 1 to 6 cycles for the next one
        lcg_state <= lcg_next;
        if (rd_req) begin
          rd_valid <= 1'b1;
          for (int b = 0; b < 8; b++)
            rd_data[8*b +: 8] <= (b < int'(rd_size)) ?
                                 mem_image[(int'(rd_addr) + b) % mem_bytes] : 8'h00;
        end else begin
          wr_ack <= 1'b1;                          // Byte 0 of the word lands at wr_addr
          for (int b = 0; b < 8; b++)
            if (b < int'(wr_size))
              mem_image[(int'(wr_addr) + b) % mem_bytes] <= wr_data[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/cgol_torus_accel_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module cgol_torus_accel_tb;

  localparam int num_tests   = 8;
  localparam int mem_bytes   = 512;
  localparam int pat_blinker = 0;
  localparam int pat_glider  = 1;
  localparam int pat_random  = 2;
  localparam int pat_empty   = 3;
  localparam int pat_full    = 4;

  // Grid width, height, base byte address and starting pattern per test
  localparam int tbl_width   [num_tests] = '{16,  16,   8,  24, 64, 16,   8,  24};
  localparam int tbl_height  [num_tests] = '{ 8,   8,   3,   5, 64,  4,   5,  64};
  localparam int tbl_base    [num_tests] = '{ 0, 200, 100, 300,  0, 40, 480, 256};
  localparam int tbl_pattern [num_tests] = '{pat_blinker, pat_glider, pat_random, pat_random,
                                             pat_random, pat_empty, pat_full, pat_random};

  logic                                               clk;
  logic                                               rst_n;
  cgol_regs_pkg::reg_t [cgol_regs_pkg::num_regs-1:0]  host_regs;
  logic [cgol_regs_pkg::num_regs-1:0]                 host_regs_valid_pulse;
  logic [cgol_regs_pkg::num_regs-1:0]                 host_regs_read_pulse;
  cgol_regs_pkg::reg_t [cgol_regs_pkg::num_regs-1:0]  host_regs_data_out;
  logic [cgol_regs_pkg::num_regs-1:0]                 host_regs_valid_out;
  logic                                               rd_req;
  cgol_grid_pkg::addr_t                               rd_addr;
  cgol_grid_pkg::row_bytes_t                          rd_size;
  logic                                               rd_valid;
  cgol_grid_pkg::row_t                                rd_data;
  logic                                               wr_req;
  cgol_grid_pkg::addr_t                               wr_addr;
  cgol_grid_pkg::row_bytes_t                          wr_size;
  cgol_grid_pkg::row_t                                wr_data;
  logic                                               wr_ack;
  logic                                               load;
  logic [mem_bytes-1:0][7:0]                          load_image;
  logic [mem_bytes-1:0][7:0]                          mem_image;

  cgol_grid_pkg::row_t        cur_grid  [cgol_grid_pkg::max_height];  // Generation before
  cgol_grid_pkg::row_t        next_grid [cgol_grid_pkg::max_height];  // Reference result
  logic [mem_bytes-1:0][7:0]  init_img;
  logic [mem_bytes-1:0][7:0]  expect_img;
  logic [31:0]                rand_state;
  int                         err_cnt;
  int                         tests_ok;
  int                         tests_bad;

  cgol_torus_accel cgol_torus_accel_i (.*);
  cgol_mem_model mem_model_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;                         // 125 MHz
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Background bytes outside the grid follow the whole address
  function automatic logic [7:0] fill_byte(input int a);
    return 8'(a) ^ 8'(a >> 1) ^ 8'h5c;
  endfunction

  function automatic string pattern_name(input int pat);
    case (pat)
      pat_blinker: return "blinker";
      pat_glider:  return "glider";
      pat_random:  return "random";
      pat_empty:   return "empty";
      default:     return "full";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] want);
    if (got !== want) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, want);
      err_cnt++;
    end
  endtask

  // Only the done word may show the flag and a valid bit
  task automatic check_done_status(input logic done);
    logic [31:0] want_data;
    logic        want_valid;
    for (int i = 0; i < cgol_regs_pkg::num_regs; i++) begin
      want_data  = (i == int'(cgol_regs_pkg::done_reg)) ? {31'd0, done} : 32'd0;
      want_valid = (i == int'(cgol_regs_pkg::done_reg)) ? done : 1'b0;
      check_value($sformatf("host_regs_data_out[%0d]", i), host_regs_data_out[i], want_data);
      check_value($sformatf("host_regs_valid_out[%0d]", i), host_regs_valid_out[i],
                  want_valid);
    end
  endtask

  task automatic build_grid(input int w, input int h, input int pat);
    for (int r = 0; r < cgol_grid_pkg::max_height; r++)
      cur_grid[r] = '0;
    case (pat)
      pat_blinker: begin
        for (int r = 3; r <= 5; r++)
          cur_grid[r][7] = 1'b1;                   // Vertical bar well inside the grid
      end
      pat_glider: begin                            // Straddles last row and last column
        cur_grid[h-2][w-1] = 1'b1;
        cur_grid[h-1][0]   = 1'b1;
        cur_grid[0][w-2]   = 1'b1;
        cur_grid[0][w-1]   = 1'b1;
        cur_grid[0][0]     = 1'b1;
      end
      pat_random: begin
        for (int r = 0; r < h; r++)
          for (int b = 0; b < w / 8; b++) begin
            rand_state = lcg_step(rand_state);
            cur_grid[r][8*b +: 8] = rand_state[23:16];
          end
      end
      pat_full: begin
        for (int r = 0; r < h; r++)
          for (int c = 0; c < w; c++)
            cur_grid[r][c] = 1'b1;
      end
      default: ;                                   // Empty grid
    endcase
  endtask

  // Reference torus model that counts the eight neighbours directly
  task automatic next_generation(input int w, input int h);
    int n;
    for (int r = 0; r < h; r++) begin
      next_grid[r] = '0;
      for (int c = 0; c < w; c++) begin
        n = 0;
        for (int dr = -1; dr <= 1; dr++)
          for (int dc = -1; dc <= 1; dc++)
            if (dr != 0 || dc != 0)
              n += int'(cur_grid[(r + dr + h) % h][(c + dc + w) % w]);
        next_grid[r][c] = (n == 3) || (cur_grid[r][c] && n == 2);
      end
    end
  endtask

  task automatic build_images(input int w, input int h, input int base);
    int a;
    for (int i = 0; i < mem_bytes; i++) begin
      init_img[i]   = fill_byte(i);
      expect_img[i] = fill_byte(i);               // Bytes past the grid must stay as they are
    end
    for (int r = 0; r < h; r++)
      for (int b = 0; b < w / 8; b++) begin
        a = base + r * (w / 8) + b;               // Rows packed back to back with column 0 in bit 0
        init_img[a]   = cur_grid[r][8*b +: 8];
        expect_img[a] = next_grid[r][8*b +: 8];
      end
  endtask

  initial begin
    int errs_at_start;
    int w;
    int h;
    int base;
    rst_n                 = 1'b0;
    host_regs             = '0;
    host_regs_valid_pulse = '0;
    host_regs_read_pulse  = '0;
    load                  = 1'b0;
    load_image            = '0;
    rand_state            = 32'd17695;
    err_cnt               = 0;
    tests_ok              = 0;
    tests_bad             = 0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    for (int t = 0; t < num_tests; t++) begin
      w             = tbl_width[t];
      h             = tbl_height[t];
      base          = tbl_base[t];
      errs_at_start = err_cnt;
      build_grid(w, h, tbl_pattern[t]);
      next_generation(w, h);
      build_images(w, h, base);
      @(posedge clk);
      load       <= 1'b1;                          // Memory preload takes one edge
      load_image <= init_img;
      host_regs[cgol_regs_pkg::grid_base_addr_reg] <= 32'(base);
      host_regs[cgol_regs_pkg::grid_width_reg]     <= 32'(w);
      host_regs[cgol_regs_pkg::grid_height_reg]    <= 32'(h);
      host_regs[cgol_regs_pkg::start_reg]          <= 32'd1;
      @(posedge clk);
      load                  <= 1'b0;
      host_regs_valid_pulse <= 5'b01111;           // Config words plus start
      @(negedge clk);
      check_done_status(1'b0);
      @(posedge clk);
      host_regs_valid_pulse                <= '0;
      host_regs[cgol_regs_pkg::start_reg]  <= '0;
      @(negedge clk);
      while (!host_regs_valid_out[cgol_regs_pkg::done_reg])
        @(negedge clk);                            // Poll done on the falling edge
      check_done_status(1'b1);
      for (int a = 0; a < mem_bytes; a++)
        check_value($sformatf("mem_image[0x%03h]", a), mem_image[a], expect_img[a]);
      @(posedge clk);
      host_regs_read_pulse[cgol_regs_pkg::done_reg] <= 1'b1;  // Software reads done
      @(posedge clk);
      host_regs_read_pulse <= '0;
      @(negedge clk);
      check_done_status(1'b0);
      if (err_cnt == errs_at_start)
        tests_ok++;
      else
        tests_bad++;
      $display("Test %0d %s %0dx%0d at 0x%03h: %s", t, pattern_name(tbl_pattern[t]), w, h,
               base, (err_cnt == errs_at_start) ? "ok" : "mismatch");
    end
    $display("Tests passed: %0d, tests failed: %0d, mismatches: %0d",
             tests_ok, tests_bad, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Generous per-row allowance summed over the whole table
  initial begin : watchdog
    int budget;
    budget = 10 + 50;
    for (int t = 0; t < num_tests; t++)
      budget += 20 * tbl_height[t] * 8 + 100;
    repeat (budget) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the DUT never reported done", budget);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
rtl/cgol_grid_pkg.sv
rtl/cgol_regs_pkg.sv
rtl/window_ctl_if.sv
rtl/cgol_host_regs.sv
rtl/cgol_row_sequencer.sv
rtl/cgol_row_window.sv
rtl/cgol_life_rule.sv
rtl/cgol_torus_accel.sv
verification/cgol_mem_model.sv
verification/cgol_torus_accel_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the torus Game of Life testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cgol_torus_accel_tb \
  -f project.f -o sim_cgol
status=0
./obj_dir/sim_cgol > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "Checks failed" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation passed"
